/* mipsPipeline.f */
+incdir+tb
src/pipelinePkg.sv
src/registerFile.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/mipsPipeline.sv
tb/mipsPipelineTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module mipsPipelineTb -f mipsPipeline.f \
	--Mdir obj_dir -o simv

./obj_dir/simv | tee sim.log

if grep -qx "Verification passed" sim.log; then
	exit 0
else
	exit 1
fi

/* src/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input wire logic clk,
	input wire logic reset,
	input wire pipelinePkg::word idInstr,
	input wire pipelinePkg::word idPcNext,
	input wire logic wbValid,
	input wire pipelinePkg::regAddr wbReg,
	input wire pipelinePkg::word wbData,
	output logic exRegWrite,
	output logic exMemToReg,
	output logic exMemRead,
	output logic exMemWrite,
	output logic exBranch,
	output logic exAluSrc,
	output logic exRegDst,
	output pipelinePkg::aluOpClass exAluOp,
	output pipelinePkg::word exRsData,
	output pipelinePkg::word exRtData,
	output pipelinePkg::word exImm,
	output pipelinePkg::regAddr exRt,
	output pipelinePkg::regAddr exRd,
	output logic [5:0] exFunct,
	output pipelinePkg::word exPcNext
);

	logic [5:0] opcode;
	pipelinePkg::regAddr rs;
	pipelinePkg::regAddr rt;
	pipelinePkg::regAddr rd;
	pipelinePkg::word rsData;
	pipelinePkg::word rtData;
	pipelinePkg::word imm;

	logic regWrite;
	logic memToReg;
	logic memRead;
	logic memWrite;
	logic branch;
	logic aluSrc;
	logic regDst;
	pipelinePkg::aluOpClass aluOp;

	// instruction fields
	assign opcode = idInstr[31:26];
	assign rs = idInstr[25:21];
	assign rt = idInstr[20:16];
	assign rd = idInstr[15:11];
	assign imm = {{16{idInstr[15]}}, idInstr[15:0]};

	registerFile registerFile_inst (
		.clk(clk),
		.reset(reset),
		.rsAddr(rs),
		.rtAddr(rt),
		.rsData(rsData),
		.rtData(rtData),
		.writeEnable(wbValid),
		.writeAddr(wbReg),
		.writeData(wbData)
	);

	////////////////////////////////////////////////////////////////////////////
	// main control
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		regWrite = 1'b0;
		memToReg = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branch = 1'b0;
		aluSrc = 1'b0;
		regDst = 1'b0;
		aluOp = pipelinePkg::aluOpMem;
		case (opcode)
			pipelinePkg::opRType: begin
				regWrite = 1'b1;
				regDst = 1'b1;
				aluOp = pipelinePkg::aluOpFunct;
			end
			pipelinePkg::opAddi: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
			end
			pipelinePkg::opLw: begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				memRead = 1'b1;
				aluSrc = 1'b1;
			end
			pipelinePkg::opSw: begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
			end
			pipelinePkg::opBeq: begin
				branch = 1'b1;
				aluOp = pipelinePkg::aluOpBranch;
			end
			// unknown opcodes pass as bubbles
			default: begin
				regWrite = 1'b0;
			end
		endcase
	end

	// ID/EX control
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			exRegWrite <= 1'b0;
			exMemToReg <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exBranch <= 1'b0;
			exAluSrc <= 1'b0;
			exRegDst <= 1'b0;
			exAluOp <= pipelinePkg::aluOpMem;
		end else begin
			exRegWrite <= regWrite;
			exMemToReg <= memToReg;
			exMemRead <= memRead;
			exMemWrite <= memWrite;
			exBranch <= branch;
			exAluSrc <= aluSrc;
			exRegDst <= regDst;
			exAluOp <= aluOp;
		end
	end

	// ID/EX operands
	always_ff @(posedge clk) begin
		exRsData <= rsData;
		exRtData <= rtData;
		exImm <= imm;
		exRt <= rt;
		exRd <= rd;
		exFunct <= idInstr[5:0];
		exPcNext <= idPcNext;
	end

endmodule

`default_nettype wire

/* src/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input wire logic clk,
	input wire logic reset,
	input wire logic exRegWrite,
	input wire logic exMemToReg,
	input wire logic exMemRead,
	input wire logic exMemWrite,
	input wire logic exBranch,
	input wire logic exAluSrc,
	input wire logic exRegDst,
	input wire pipelinePkg::aluOpClass exAluOp,
	input wire pipelinePkg::word exRsData,
	input wire pipelinePkg::word exRtData,
	input wire pipelinePkg::word exImm,
	input wire pipelinePkg::regAddr exRt,
	input wire pipelinePkg::regAddr exRd,
	input wire logic [5:0] exFunct,
	input wire pipelinePkg::word exPcNext,
	output logic memRegWrite,
	output logic memToRegOut,
	output logic memRead,
	output logic memWrite,
	output logic memBranch,
	output pipelinePkg::word memAluResult,
	output logic memAluZero,
	output pipelinePkg::word memStoreData,
	output pipelinePkg::regAddr memDestReg,
	output pipelinePkg::word memBranchTarget
);

	pipelinePkg::aluCtl ctl;
	pipelinePkg::word operandB;
	pipelinePkg::word difference;
	logic lessThan;
	pipelinePkg::word aluResult;
	pipelinePkg::regAddr destReg;
	pipelinePkg::word branchTarget;

	////////////////////////////////////////////////////////////////////////////
	// ALU control
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (exAluOp)
			pipelinePkg::aluOpMem: ctl = pipelinePkg::aluAdd;
			pipelinePkg::aluOpBranch: ctl = pipelinePkg::aluSub;
			default: begin
				case (exFunct)
					pipelinePkg::fnAdd: ctl = pipelinePkg::aluAdd;
					pipelinePkg::fnSub: ctl = pipelinePkg::aluSub;
					pipelinePkg::fnAnd: ctl = pipelinePkg::aluAnd;
					pipelinePkg::fnOr: ctl = pipelinePkg::aluOr;
					pipelinePkg::fnSlt: ctl = pipelinePkg::aluSlt;
					default: ctl = pipelinePkg::aluAdd;
				endcase
			end
		endcase
	end

	assign operandB = exAluSrc ? exImm : exRtData;
	assign difference = exRsData - operandB;

	// slt is a signed compare, immune to overflow of the difference
	assign lessThan = $signed(exRsData) < $signed(operandB);

	always_comb begin
		case (ctl)
			pipelinePkg::aluAnd: aluResult = exRsData & operandB;
			pipelinePkg::aluOr: aluResult = exRsData | operandB;
			pipelinePkg::aluSub: aluResult = difference;
			pipelinePkg::aluSlt: aluResult = {{(pipelinePkg::dataWidth-1){1'b0}}, lessThan};
			default: aluResult = exRsData + operandB;
		endcase
	end

	// rd for R-format, rt otherwise
	assign destReg = exRegDst ? exRd : exRt;
	assign branchTarget = exPcNext + {exImm[29:0], 2'b00};

	// EX/MEM control
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			memRegWrite <= 1'b0;
			memToRegOut <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
			memBranch <= 1'b0;
		end else begin
			memRegWrite <= exRegWrite;
			memToRegOut <= exMemToReg;
			memRead <= exMemRead;
			memWrite <= exMemWrite;
			memBranch <= exBranch;
		end
	end

	// EX/MEM data
	always_ff @(posedge clk) begin
		memAluResult <= aluResult;
		memAluZero <= (aluResult == '0);
		memStoreData <= exRtData;
		memDestReg <= destReg;
		memBranchTarget <= branchTarget;
	end

endmodule

`default_nettype wire

/* src/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
	input wire logic clk,
	input wire logic reset,
	input wire logic run,
	input wire logic loadValid,
	input wire logic [pipelinePkg::imemAddrWidth-1:0] loadAddr,
	input wire pipelinePkg::word loadData,
	output logic loadReady,
	input wire logic pcRedirect,
	input wire pipelinePkg::word redirectTarget,
	output pipelinePkg::word idInstr,
	output pipelinePkg::word idPcNext
);

	pipelinePkg::word pc;
	pipelinePkg::word pcNext;
	pipelinePkg::word fetched;
	logic [pipelinePkg::imemAddrWidth-1:0] fetchIndex;

	pipelinePkg::word imem [pipelinePkg::imemDepth];
	// words not loaded since reset read back as bubbles
	logic [pipelinePkg::imemDepth-1:0] wordLoaded;

	// loading only while the core is idle
	assign loadReady = !run;

	////////////////////////////////////////////////////////////////////////////
	// instruction memory
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (loadValid && loadReady) begin
			imem[loadAddr] <= loadData;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wordLoaded <= '0;
		end else if (loadValid && loadReady) begin
			wordLoaded[loadAddr] <= 1'b1;
		end
	end

	assign fetchIndex = pc[pipelinePkg::imemAddrWidth+1:2];
	assign fetched = wordLoaded[fetchIndex] ? imem[fetchIndex] : '0;

	////////////////////////////////////////////////////////////////////////////
	// program counter
	////////////////////////////////////////////////////////////////////////////
	assign pcNext = pc + pipelinePkg::pcStep;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (!run) begin
			pc <= '0;
		end else if (pcRedirect) begin
			// taken beq from the memory stage
			pc <= redirectTarget;
		end else begin
			pc <= pcNext;
		end
	end

	// IF/ID, all-zero word is a bubble while idle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			idInstr <= '0;
		end else begin
			idInstr <= run ? fetched : '0;
		end
	end

	always_ff @(posedge clk) begin
		idPcNext <= pcNext;
	end

endmodule

`default_nettype wire

/* src/memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
	input wire logic clk,
	input wire logic reset,
	input wire logic memRegWrite,
	input wire logic memToRegOut,
	input wire logic memRead,
	input wire logic memWrite,
	input wire logic memBranch,
	input wire pipelinePkg::word memAluResult,
	input wire logic memAluZero,
	input wire pipelinePkg::word memStoreData,
	input wire pipelinePkg::regAddr memDestReg,
	input wire pipelinePkg::word memBranchTarget,
	output logic pcRedirect,
	output pipelinePkg::word redirectTarget,
	output logic wbValid,
	output pipelinePkg::regAddr wbReg,
	output pipelinePkg::word wbData
);

	pipelinePkg::word dmem [pipelinePkg::dmemDepth];
	// unwritten words read as zero
	logic [pipelinePkg::dmemDepth-1:0] wordWritten;
	logic [pipelinePkg::dmemAddrWidth-1:0] wordIndex;
	pipelinePkg::word readData;

	logic wbMemToReg;
	pipelinePkg::word wbLoadData;
	pipelinePkg::word wbAluResult;

	// byte address from the ALU, low two bits dropped
	assign wordIndex = memAluResult[pipelinePkg::dmemAddrWidth+1:2];

	always_ff @(posedge clk) begin
		if (memWrite) begin
			dmem[wordIndex] <= memStoreData;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wordWritten <= '0;
		end else if (memWrite) begin
			wordWritten[wordIndex] <= 1'b1;
		end
	end

	assign readData = (memRead && wordWritten[wordIndex]) ? dmem[wordIndex] : '0;

	// beq taken when operands matched
	assign pcRedirect = memBranch && memAluZero;
	assign redirectTarget = memBranchTarget;

	////////////////////////////////////////////////////////////////////////////
	// MEM/WB and writeback select
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wbValid <= 1'b0;
			wbMemToReg <= 1'b0;
		end else begin
			wbValid <= memRegWrite && (memDestReg != '0);
			wbMemToReg <= memToRegOut;
		end
	end

	always_ff @(posedge clk) begin
		wbReg <= memDestReg;
		wbLoadData <= readData;
		wbAluResult <= memAluResult;
	end

	assign wbData = wbMemToReg ? wbLoadData : wbAluResult;

endmodule

`default_nettype wire

/* src/mipsPipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsPipeline (
	input wire logic clk,
	input wire logic reset,
	input wire logic run,
	input wire logic loadValid,
	input wire logic [pipelinePkg::imemAddrWidth-1:0] loadAddr,
	input wire pipelinePkg::word loadData,
	output logic loadReady,
	output logic wbValid,
	output pipelinePkg::regAddr wbReg,
	output pipelinePkg::word wbData
);

	// fetch to decode
	pipelinePkg::word idInstr;
	pipelinePkg::word idPcNext;

	// decode to execute
	logic exRegWrite;
	logic exMemToReg;
	logic exMemRead;
	logic exMemWrite;
	logic exBranch;
	logic exAluSrc;
	logic exRegDst;
	pipelinePkg::aluOpClass exAluOp;
	pipelinePkg::word exRsData;
	pipelinePkg::word exRtData;
	pipelinePkg::word exImm;
	pipelinePkg::regAddr exRt;
	pipelinePkg::regAddr exRd;
	logic [5:0] exFunct;
	pipelinePkg::word exPcNext;

	// execute to memory
	logic memRegWrite;
	logic memToRegOut;
	logic memRead;
	logic memWrite;
	logic memBranch;
	pipelinePkg::word memAluResult;
	logic memAluZero;
	pipelinePkg::word memStoreData;
	pipelinePkg::regAddr memDestReg;
	pipelinePkg::word memBranchTarget;

	// memory back to fetch
	logic pcRedirect;
	pipelinePkg::word redirectTarget;

	fetchStage fetchStage_inst (
		.clk(clk),
		.reset(reset),
		.run(run),
		.loadValid(loadValid),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.loadReady(loadReady),
		.pcRedirect(pcRedirect),
		.redirectTarget(redirectTarget),
		.idInstr(idInstr),
		.idPcNext(idPcNext)
	);

	decodeStage decodeStage_inst (
		.clk(clk),
		.reset(reset),
		.idInstr(idInstr),
		.idPcNext(idPcNext),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.exRegWrite(exRegWrite),
		.exMemToReg(exMemToReg),
		.exMemRead(exMemRead),
		.exMemWrite(exMemWrite),
		.exBranch(exBranch),
		.exAluSrc(exAluSrc),
		.exRegDst(exRegDst),
		.exAluOp(exAluOp),
		.exRsData(exRsData),
		.exRtData(exRtData),
		.exImm(exImm),
		.exRt(exRt),
		.exRd(exRd),
		.exFunct(exFunct),
		.exPcNext(exPcNext)
	);

	executeStage executeStage_inst (
		.clk(clk),
		.reset(reset),
		.exRegWrite(exRegWrite),
		.exMemToReg(exMemToReg),
		.exMemRead(exMemRead),
		.exMemWrite(exMemWrite),
		.exBranch(exBranch),
		.exAluSrc(exAluSrc),
		.exRegDst(exRegDst),
		.exAluOp(exAluOp),
		.exRsData(exRsData),
		.exRtData(exRtData),
		.exImm(exImm),
		.exRt(exRt),
		.exRd(exRd),
		.exFunct(exFunct),
		.exPcNext(exPcNext),
		.memRegWrite(memRegWrite),
		.memToRegOut(memToRegOut),
		.memRead(memRead),
		.memWrite(memWrite),
		.memBranch(memBranch),
		.memAluResult(memAluResult),
		.memAluZero(memAluZero),
		.memStoreData(memStoreData),
		.memDestReg(memDestReg),
		.memBranchTarget(memBranchTarget)
	);

	memoryStage memoryStage_inst (
		.clk(clk),
		.reset(reset),
		.memRegWrite(memRegWrite),
		.memToRegOut(memToRegOut),
		.memRead(memRead),
		.memWrite(memWrite),
		.memBranch(memBranch),
		.memAluResult(memAluResult),
		.memAluZero(memAluZero),
		.memStoreData(memStoreData),
		.memDestReg(memDestReg),
		.memBranchTarget(memBranchTarget),
		.pcRedirect(pcRedirect),
		.redirectTarget(redirectTarget),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

`default_nettype wire

/* src/pipelinePkg.sv */
`default_nettype none

package pipelinePkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and basic types
	////////////////////////////////////////////////////////////////////////////
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 2 ** regAddrWidth;

	typedef logic [dataWidth-1:0] word;
	typedef logic [regAddrWidth-1:0] regAddr;

	// memories hold whole words, indexed by byte address bits above [1:0]
	localparam int imemDepth = 64;
	localparam int imemAddrWidth = $clog2(imemDepth);
	localparam int dmemDepth = 64;
	localparam int dmemAddrWidth = $clog2(dmemDepth);

	localparam word pcStep = 32'd4;

	////////////////////////////////////////////////////////////////////////////
	// instruction encodings
	////////////////////////////////////////////////////////////////////////////
	localparam logic [5:0] opRType = 6'b000000;
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opLw = 6'b100011;
	localparam logic [5:0] opSw = 6'b101011;
	localparam logic [5:0] opBeq = 6'b000100;

	// function field of R-format
	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnSlt = 6'b101010;

	////////////////////////////////////////////////////////////////////////////
	// ALU operation classes and controls
	////////////////////////////////////////////////////////////////////////////
	// class chosen by decode, refined in execute
	typedef enum logic [1:0] {
		aluOpMem = 2'b00,
		aluOpBranch = 2'b01,
		aluOpFunct = 2'b10
	} aluOpClass;

	typedef enum logic [3:0] {
		aluAnd = 4'b0000,
		aluOr = 4'b0001,
		aluAdd = 4'b0010,
		aluSub = 4'b0110,
		aluSlt = 4'b0111
	} aluCtl;

endpackage

`default_nettype wire

/* src/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input wire logic clk,
	input wire logic reset,
	input wire pipelinePkg::regAddr rsAddr,
	input wire pipelinePkg::regAddr rtAddr,
	output pipelinePkg::word rsData,
	output pipelinePkg::word rtData,
	input wire logic writeEnable,
	input wire pipelinePkg::regAddr writeAddr,
	input wire pipelinePkg::word writeData
);

	pipelinePkg::word regs [pipelinePkg::regCount];
	logic rsHit;
	logic rtHit;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < pipelinePkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// same-cycle write is visible to the reader
	assign rsHit = writeEnable && (writeAddr == rsAddr);
	assign rtHit = writeEnable && (writeAddr == rtAddr);

	// $0 always reads zero
	assign rsData = (rsAddr == '0) ? '0 :
		rsHit ? writeData : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 :
		rtHit ? writeData : regs[rtAddr];

endmodule

`default_nettype wire

/* tb/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// random program generator
////////////////////////////////////////////////////////////////////////////
localparam int kindAddi = 0;
localparam int kindAdd = 1;
localparam int kindSub = 2;
localparam int kindAnd = 3;
localparam int kindOr = 4;
localparam int kindSlt = 5;
localparam int kindLw = 6;
localparam int kindSw = 7;
localparam int kindBeq = 8;
localparam int maxInstr = 12;

int instrCount;
int instrKind [maxInstr];
pipelinePkg::regAddr instrRs [maxInstr];
pipelinePkg::regAddr instrRt [maxInstr];
pipelinePkg::regAddr instrRd [maxInstr];
logic [15:0] instrImm [maxInstr];
pipelinePkg::word programWords [pipelinePkg::imemDepth];
int programLength;

// model state and the writes it expects, in order
pipelinePkg::word modelRegs [32];
pipelinePkg::word modelMem [pipelinePkg::dmemDepth];
pipelinePkg::regAddr expectReg [$];
pipelinePkg::word expectData [$];
int expectedWrites;
int executedCount;

function automatic pipelinePkg::word encodeInstr(input int k);
	case (instrKind[k])
		kindAddi: return {pipelinePkg::opAddi, instrRs[k], instrRt[k], instrImm[k]};
		kindLw: return {pipelinePkg::opLw, instrRs[k], instrRt[k], instrImm[k]};
		kindSw: return {pipelinePkg::opSw, instrRs[k], instrRt[k], instrImm[k]};
		kindBeq: return {pipelinePkg::opBeq, instrRs[k], instrRt[k], instrImm[k]};
		kindAdd: return {pipelinePkg::opRType, instrRs[k], instrRt[k], instrRd[k], 5'd0,
			pipelinePkg::fnAdd};
		kindSub: return {pipelinePkg::opRType, instrRs[k], instrRt[k], instrRd[k], 5'd0,
			pipelinePkg::fnSub};
		kindAnd: return {pipelinePkg::opRType, instrRs[k], instrRt[k], instrRd[k], 5'd0,
			pipelinePkg::fnAnd};
		kindOr: return {pipelinePkg::opRType, instrRs[k], instrRt[k], instrRd[k], 5'd0,
			pipelinePkg::fnOr};
		default: return {pipelinePkg::opRType, instrRs[k], instrRt[k], instrRd[k], 5'd0,
			pipelinePkg::fnSlt};
	endcase
endfunction

task automatic generateProgram();
	int span;
	instrCount = 1 + int'($unsigned($random(seed)) % maxInstr);
	for (int k = 0; k < instrCount; k++) begin
		instrKind[k] = int'($unsigned($random(seed)) % 9);
		instrRs[k] = 5'($unsigned($random(seed)) % 8);
		instrRt[k] = 5'($unsigned($random(seed)) % 8);
		instrRd[k] = 5'($unsigned($random(seed)) % 8);
		instrImm[k] = 16'($random(seed));
		if (instrKind[k] == kindLw || instrKind[k] == kindSw) begin
			// $0 base, word-aligned offset in the first eight words
			instrRs[k] = 5'd0;
			instrImm[k] = 16'(4 * ($unsigned($random(seed)) % 8));
		end else if (instrKind[k] == kindBeq) begin
			// few registers so that operands often match
			instrRs[k] = 5'($unsigned($random(seed)) % 3);
			instrRt[k] = 5'($unsigned($random(seed)) % 3);
			span = 1 + int'($unsigned($random(seed)) % (instrCount - k));
			// lands on a later real instruction or just past the end
			instrImm[k] = 16'(4 * span - 1);
		end
	end
	foreach (programWords[i]) begin
		programWords[i] = '0;
	end
	// three zero words after every real one
	for (int k = 0; k < instrCount; k++) begin
		programWords[4 * k] = encodeInstr(k);
	end
	programLength = 4 * instrCount;
endtask

////////////////////////////////////////////////////////////////////////////
// instruction-level model
////////////////////////////////////////////////////////////////////////////
task automatic runModel();
	pipelinePkg::word a;
	pipelinePkg::word b;
	pipelinePkg::word imm;
	pipelinePkg::word addr;
	pipelinePkg::word diff;
	pipelinePkg::word result;
	pipelinePkg::regAddr dest;
	logic [pipelinePkg::dmemAddrWidth-1:0] wordIndex;
	logic writes;
	int k;
	int targetWord;
	foreach (modelRegs[i]) begin
		modelRegs[i] = '0;
	end
	foreach (modelMem[i]) begin
		modelMem[i] = '0;
	end
	expectReg.delete();
	expectData.delete();
	executedCount = 0;
	k = 0;
	while (k < instrCount) begin
		a = modelRegs[instrRs[k]];
		b = modelRegs[instrRt[k]];
		imm = {{16{instrImm[k][15]}}, instrImm[k]};
		addr = a + imm;
		wordIndex = addr[pipelinePkg::dmemAddrWidth+1:2];
		diff = a - b;
		dest = instrRd[k];
		writes = 1'b1;
		result = '0;
		executedCount++;
		case (instrKind[k])
			kindAddi: begin
				result = a + imm;
				dest = instrRt[k];
			end
			kindAdd: result = a + b;
			kindSub: result = diff;
			kindAnd: result = a & b;
			kindOr: result = a | b;
			// 1 when the true signed difference is negative
			kindSlt: result = (longint'($signed(a)) - longint'($signed(b)) < 0) ? 32'd1 : 32'd0;
			kindLw: begin
				result = modelMem[wordIndex];
				dest = instrRt[k];
			end
			kindSw: begin
				modelMem[wordIndex] = b;
				writes = 1'b0;
			end
			default: writes = 1'b0;
		endcase
		if (writes && dest != 5'd0) begin
			modelRegs[dest] = result;
			expectReg.push_back(dest);
			expectData.push_back(result);
		end
		// target is the word after beq plus the offset in words
		if (instrKind[k] == kindBeq && a == b) begin
			targetWord = 4 * k + 1 + int'($signed(instrImm[k]));
			k = targetWord / 4;
		end else begin
			k = k + 1;
		end
	end
	expectedWrites = expectReg.size();
endtask

`endif

/* tb/mipsPipelineTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsPipelineTb;

	logic clk;
	logic reset;
	logic run;
	logic loadValid;
	logic [pipelinePkg::imemAddrWidth-1:0] loadAddr;
	pipelinePkg::word loadData;
	logic loadReady;
	logic wbValid;
	pipelinePkg::regAddr wbReg;
	pipelinePkg::word wbData;

	int seed;
	int checkCount;
	int wbCount;
	// set once run has been seen high since the last reset
	logic runSeen;

	`include "isaModel.svh"

	localparam int programCount = 10;
	// 10 cycles per program word plus 50
	localparam int watchdogCycles = programCount * maxInstr * 4 * 10 + 50;

	mipsPipeline mipsPipeline_inst (
		.clk(clk),
		.reset(reset),
		.run(run),
		.loadValid(loadValid),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.loadReady(loadReady),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////
	task automatic stopWithFailure();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input pipelinePkg::word actual,
		input pipelinePkg::word expected);
		checkCount++;
		if (actual !== expected) begin
			$display("ERROR at %0t: %s is 0x%08h, expected 0x%08h", $time, name, actual,
				expected);
			stopWithFailure();
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			runSeen = 1'b0;
		end else if (run) begin
			runSeen = 1'b1;
		end
		// load port closed while running
		checkValue("loadReady", 32'(loadReady), run ? 32'd0 : 32'd1);
	end

	// writeback port sampled mid-cycle
	always @(negedge clk) begin
		if (wbValid) begin
			if (!runSeen) begin
				$display("wbValid went high at %0t before run was raised", $time);
				stopWithFailure();
			end else if (expectReg.size() == 0) begin
				$display("unexpected write to register %0d at %0t", wbReg, $time);
				stopWithFailure();
			end else begin
				checkValue("wbReg", 32'(wbReg), 32'(expectReg.pop_front()));
				checkValue("wbData", wbData, expectData.pop_front());
				wbCount++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////
	task automatic applyReset();
		@(negedge clk);
		reset = 1'b1;
		run = 1'b0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		wbCount = 0;
	endtask

	task automatic loadProgram();
		for (int i = 0; i < programLength; i++) begin
			@(negedge clk);
			while (!loadReady) @(negedge clk);
			loadValid = 1'b1;
			loadAddr = i[pipelinePkg::imemAddrWidth-1:0];
			loadData = programWords[loadAddr];
			@(posedge clk);
		end
		@(negedge clk);
		loadValid = 1'b0;
	endtask

	task automatic executeProgram();
		@(negedge clk);
		run = 1'b1;
		// each executed instruction takes four fetch slots, then the pipe drains
		repeat (4 * executedCount + 8) @(negedge clk);
		run = 1'b0;
		repeat (8) @(negedge clk);
		checkValue("writeback count", 32'(wbCount), 32'(expectedWrites));
	endtask

	initial begin
		reset = 1'b1;
		run = 1'b0;
		loadValid = 1'b0;
		loadAddr = '0;
		loadData = '0;
		runSeen = 1'b0;
		seed = 99806;
		checkCount = 0;
		wbCount = 0;
		for (int p = 0; p < programCount; p++) begin
			applyReset();
			generateProgram();
			runModel();
			loadProgram();
			executeProgram();
		end
		if (checkCount > 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("no values were checked");
			stopWithFailure();
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout: run still going after %0d cycles", watchdogCycles);
		stopWithFailure();
	end

endmodule

`default_nettype wire
